// ==== Bender.yml ====
package:
  name: mcoi_app

sources:
  # design sources, package first
  - logic/mcoi_pkg.sv
  - logic/ps_buffer_reader.sv
  - logic/motor_io.sv
  - logic/readout_mux.sv
  - logic/mcoi_app_core.sv
  # testbench sources for simulation
  - target: test
    files:
      - test/mcoi_app_checker.sv
      - test/mcoi_app_tb.sv

// ==== logic/mcoi_app_core.sv ====
// gbt side application core of the motor controller
// ties buffer reader, motor pin interface and readout multiplexer
module mcoi_app_core import mcoi_pkg::*; #(
   parameter int          num_motors   = 16,
   parameter int          ps_addr_bits = 4,
   parameter logic [31:0] build_number = 32'h0
) (
   input  logic                         gbt_rx_clkrs,
   input  logic                         reset_i,
   // processor buffer and status
   input  logic [15:0]                  ps_status_i,
   input  ps_word_t                     ps_dout_i,
   output logic [ps_addr_bits-1:0]      ps_addr_o,
   output logic                         progress_o,
   // motor control and driver pins
   input  motor_ctrl_t [num_motors-1:0] motor_frame_i,
   input  logic [31:0]                  feedback_i,
   output logic [num_motors-1:0]        pl_boost_o,
   output logic [num_motors-1:0]        pl_dir_o,
   output logic [num_motors-1:0]        pl_en_o,
   output logic [num_motors-1:0]        pl_clk_o,
   input  logic [num_motors-1:0]        pl_pfail_i,
   input  logic [num_motors-1:0]        pl_sw_outa_i,
   input  logic [num_motors-1:0]        pl_sw_outb_i,
   output logic [num_motors*4-1:0]      status_frame_o,
   // readout side
   input  logic                         rx_clken_i,
   input  logic [31:0]                  page_sel_i,
   input  logic                         page_valid_i,
   input  logic [3:0]                   pcbrev_i,
   input  logic                         rs485_ro_i,
   output logic                         rs485_di_o,
   output logic [31:0]                  readout_o
);

   sensor_block_t                sensors;
   motor_stat_t [num_motors-1:0] motor_stat;

   ps_buffer_reader #(
      .ps_addr_bits (ps_addr_bits)
   ) i_ps_buffer_reader (
      .gbt_rx_clkrs (gbt_rx_clkrs),
      .reset_i      (reset_i),
      .ps_status_i  (ps_status_i),
      .ps_dout_i    (ps_dout_i),
      .ps_addr_o    (ps_addr_o),
      .progress_o   (progress_o),
      .sensors_o    (sensors)
   );

   motor_io #(
      .num_motors (num_motors)
   ) i_motor_io (
      .gbt_rx_clkrs  (gbt_rx_clkrs),
      .reset_i       (reset_i),
      .motor_frame_i (motor_frame_i),
      .feedback_i    (feedback_i),
      .pl_boost_o    (pl_boost_o),
      .pl_dir_o      (pl_dir_o),
      .pl_en_o       (pl_en_o),
      .pl_clk_o      (pl_clk_o),
      .pl_pfail_i    (pl_pfail_i),
      .pl_sw_outa_i  (pl_sw_outa_i),
      .pl_sw_outb_i  (pl_sw_outb_i),
      .motor_stat_o  (motor_stat)
   );

   readout_mux #(
      .num_motors   (num_motors),
      .build_number (build_number)
   ) i_readout_mux (
      .gbt_rx_clkrs (gbt_rx_clkrs),
      .reset_i      (reset_i),
      .rx_clken_i   (rx_clken_i),
      .page_sel_i   (page_sel_i),
      .page_valid_i (page_valid_i),
      .sensors_i    (sensors),
      .pcbrev_i     (pcbrev_i),
      .rs485_ro_i   (rs485_ro_i),
      .motor_stat_i (motor_stat),
      .readout_o    (readout_o)
   );

   // synchronized statuses go back in the transmit frame
   assign status_frame_o = motor_stat;

   // rs485 driver input rides on selector bit 8
   assign rs485_di_o = page_sel_i[8];

endmodule

// ==== logic/mcoi_pkg.sv ====
// mcoi application package
// frame, status and buffer word types, page and state encodings, constants
package mcoi_pkg;

   // -------------------------------------------------------------------
   // motor side
   // -------------------------------------------------------------------

   // one motor's control as received in the gbt frame
   typedef struct packed {
      logic boost;
      logic dir;
      // high deactivates the driver
      logic deactivate;
      logic step_out;
   } motor_ctrl_t;

   // one motor's status as echoed back in the transmit frame
   typedef struct packed {
      logic       pfail;
      // bit 0 is switch a, bit 1 is switch b
      logic [1:0] raw_sw;
      logic       overheat;
   } motor_stat_t;

   // -------------------------------------------------------------------
   // processor buffer
   // -------------------------------------------------------------------

   // buffer word layout as written by the processor application
   typedef struct packed {
      logic [7:0]  id;
      logic [7:0]  reserved;
      logic [15:0] value;
   } ps_word_t;

   // decoded sensor values handed to the readout
   typedef struct packed {
      logic [63:0] unique_id;
      logic [31:0] temperature;
      logic [31:0] power;
   } sensor_block_t;

   typedef enum logic [1:0] {
      wait_for_start,
      read_all_data,
      finished
   } reader_state_e;

   // tags found in the id field of a buffer word
   typedef enum logic [7:0] {
      id_uid0  = 8'd1,
      id_uid1  = 8'd2,
      id_uid2  = 8'd4,
      id_uid3  = 8'd5,
      id_power = 8'd10,
      id_temp  = 8'd13
   } ps_id_e;

   // -------------------------------------------------------------------
   // readout pages
   // -------------------------------------------------------------------

   typedef enum logic [7:0] {
      page_loopback   = 8'd0,
      page_build      = 8'd1,
      page_pcbrev     = 8'd2,
      page_uid_hi     = 8'd3,
      page_uid_lo     = 8'd4,
      page_temp       = 8'd5,
      page_power      = 8'd6,
      page_one        = 8'd7,
      page_rs485      = 8'd8,
      // first per-motor status page
      page_motor_base = 8'd16
   } page_e;

   // feedback value that closes the motor interlock
   localparam logic [31:0] interlock_word   = 32'hC0DE_600D;
   // filler shown on pages that carry nothing
   localparam logic [31:0] unused_page_word = 32'hDEAD_BEEF;
   // depth of the status synchronizer
   localparam int          sync_stages      = 3;
   // start flag position in the processor status word
   localparam int          ps_start_bit     = 3;

endpackage

// ==== logic/motor_io.sv ====
// motor pin interface
// interlocked control to the driver pins, synchronized driver status back
module motor_io import mcoi_pkg::*; #(
   parameter int num_motors = 16
) (
   input  logic                             gbt_rx_clkrs,
   input  logic                             reset_i,
   input  motor_ctrl_t [num_motors-1:0]     motor_frame_i,
   input  logic [31:0]                      feedback_i,
   output logic [num_motors-1:0]            pl_boost_o,
   output logic [num_motors-1:0]            pl_dir_o,
   output logic [num_motors-1:0]            pl_en_o,
   output logic [num_motors-1:0]            pl_clk_o,
   input  logic [num_motors-1:0]            pl_pfail_i,
   input  logic [num_motors-1:0]            pl_sw_outa_i,
   input  logic [num_motors-1:0]            pl_sw_outb_i,
   output motor_stat_t [num_motors-1:0]     motor_stat_o
);

   // registered control after the interlock
   motor_ctrl_t [num_motors-1:0] ctrl_q;

   // status before and inside the synchronizer
   motor_stat_t [num_motors-1:0]                  stat_raw;
   motor_stat_t [sync_stages-1:0][num_motors-1:0] sync_q;

   // -------------------------------------------------------------------
   // control path
   // -------------------------------------------------------------------
   // frame passes only while the feedback loop is closed
   // all ones sets deactivate on every driver, so an open loop
   // or a link coming up leaves the motors parked
   always_ff @(posedge gbt_rx_clkrs) begin
      if (reset_i) begin
         ctrl_q <= '1;
      end else if (feedback_i == interlock_word) begin
         ctrl_q <= motor_frame_i;
      end else begin
         ctrl_q <= '1;
      end
   end

   // -------------------------------------------------------------------
   // pin mapping
   // -------------------------------------------------------------------
   for (genvar m = 0; m < num_motors; m++) begin : g_pins
      assign pl_boost_o[m] = ctrl_q[m].boost;
      assign pl_dir_o[m]   = ctrl_q[m].dir;
      // driver enable pin is active low
      assign pl_en_o[m]    = ctrl_q[m].deactivate;
      assign pl_clk_o[m]   = ctrl_q[m].step_out;

      // status pins are active low
      assign stat_raw[m].pfail     = ~pl_pfail_i[m];
      assign stat_raw[m].raw_sw[0] = ~pl_sw_outa_i[m];
      assign stat_raw[m].raw_sw[1] = ~pl_sw_outb_i[m];
      // no overheat line on this board
      assign stat_raw[m].overheat  = 1'b0;
   end

   // -------------------------------------------------------------------
   // status synchronizer
   // -------------------------------------------------------------------
   // pins are asynchronous to the gbt clock
   // stage 0 takes the pins, last stage feeds the outputs
   always_ff @(posedge gbt_rx_clkrs) begin
      if (reset_i) begin
         sync_q <= '0;
      end else begin
         sync_q <= {sync_q[sync_stages-2:0], stat_raw};
      end
   end

   assign motor_stat_o = sync_q[sync_stages-1];

   // open loop must park every driver on the following cycle
   a_interlock_open : assert property (
      @(posedge gbt_rx_clkrs) disable iff (reset_i)
      (feedback_i != interlock_word) |=> (pl_en_o == '1)
   );

endmodule

// ==== logic/ps_buffer_reader.sv ====
// processor buffer reader
// sweeps the buffer, decodes id tagged words into sensor registers
module ps_buffer_reader import mcoi_pkg::*; #(
   parameter int ps_addr_bits = 4
) (
   input  logic                    gbt_rx_clkrs,
   input  logic                    reset_i,
   input  logic [15:0]             ps_status_i,
   input  ps_word_t                ps_dout_i,
   output logic [ps_addr_bits-1:0] ps_addr_o,
   output logic                    progress_o,
   output sensor_block_t           sensors_o
);

   reader_state_e state_q;

   // registered buffer word and its valid flag
   ps_word_t word_q;
   logic     word_vld_q;

   // working registers filled during a sweep
   logic [63:0] uid_q;
   logic [15:0] power_lo_q;
   logic [15:0] temp_lo_q;

   sensor_block_t sensors_work;

   // -------------------------------------------------------------------
   // sweep fsm
   // -------------------------------------------------------------------
   // every sweep starts at address 0 and ends when the address wraps
   // progress is raised only when the processor asked for the sweep
   always_ff @(posedge gbt_rx_clkrs) begin
      if (reset_i) begin
         state_q    <= wait_for_start;
         ps_addr_o  <= '0;
         progress_o <= 1'b0;
         word_vld_q <= 1'b0;
      end else begin
         word_vld_q <= 1'b0;
         case (state_q)
            wait_for_start: begin
               // processor polls progress to see its request taken
               progress_o <= ps_status_i[ps_start_bit];
               state_q    <= read_all_data;
            end
            read_all_data: begin
               word_vld_q <= 1'b1;
               ps_addr_o  <= ps_addr_o + ps_addr_bits'(1);
               // last address, next one wraps to zero
               if (ps_addr_o == '1) begin
                  state_q <= finished;
               end
            end
            finished: begin
               progress_o <= 1'b0;
               state_q    <= wait_for_start;
            end
            default: begin
               state_q <= wait_for_start;
            end
         endcase
      end
   end

   // buffer answers in the same cycle so the word is taken right away
   always_ff @(posedge gbt_rx_clkrs) begin
      if (state_q == read_all_data) begin
         word_q <= ps_dout_i;
      end
   end

   // -------------------------------------------------------------------
   // id decode
   // -------------------------------------------------------------------
   always_ff @(posedge gbt_rx_clkrs) begin
      if (reset_i) begin
         uid_q      <= '0;
         power_lo_q <= '0;
         temp_lo_q  <= '0;
      end else if (word_vld_q) begin
         case (word_q.id)
            // unique id comes in four slices, low slice first
            id_uid0:  uid_q[15:0]  <= word_q.value;
            id_uid1:  uid_q[31:16] <= word_q.value;
            id_uid2:  uid_q[47:32] <= word_q.value;
            id_uid3:  uid_q[63:48] <= word_q.value;
            id_power: power_lo_q   <= word_q.value;
            id_temp:  temp_lo_q    <= word_q.value;
            // other tags are not ours
            default: ;
         endcase
      end
   end

   always_comb begin
      sensors_work.unique_id   = uid_q;
      sensors_work.temperature = {16'b0, temp_lo_q};
      sensors_work.power       = {16'b0, power_lo_q};
   end

   // shadow copy keeps half written values away from the readout
   always_ff @(posedge gbt_rx_clkrs) begin
      if (!progress_o) begin
         sensors_o <= sensors_work;
      end
   end

   // progress may only be raised from the idle state
   a_progress_rise : assert property (
      @(posedge gbt_rx_clkrs) disable iff (reset_i)
      $rose(progress_o) |-> $past(state_q == wait_for_start)
   );

endmodule

// ==== logic/readout_mux.sv ====
// readout page multiplexer
// loopback register and selection of the 32 bit readout word
module readout_mux import mcoi_pkg::*; #(
   parameter int          num_motors   = 16,
   parameter logic [31:0] build_number = 32'h0
) (
   input  logic                         gbt_rx_clkrs,
   input  logic                         reset_i,
   input  logic                         rx_clken_i,
   input  logic [31:0]                  page_sel_i,
   input  logic                         page_valid_i,
   input  sensor_block_t                sensors_i,
   input  logic [3:0]                   pcbrev_i,
   input  logic                         rs485_ro_i,
   input  motor_stat_t [num_motors-1:0] motor_stat_i,
   output logic [31:0]                  readout_o
);

   logic [31:0] loopback_q;
   logic [31:0] mux_word;

   // page number and motor index behind it
   logic [7:0] page;
   logic [7:0] motor_idx;

   // -------------------------------------------------------------------
   // loopback
   // -------------------------------------------------------------------
   // bit 0 set tells the host the link is alive
   always_ff @(posedge gbt_rx_clkrs) begin
      if (reset_i) begin
         loopback_q <= 32'd1;
      end else if (page_valid_i) begin
         loopback_q <= {page_sel_i[31], 30'b0, 1'b1};
      end
   end

   // -------------------------------------------------------------------
   // page selection
   // -------------------------------------------------------------------
   // only the low byte of the selector picks the page
   assign page      = page_sel_i[7:0];
   assign motor_idx = page - page_motor_base;

   always_comb begin
      case (page)
         page_loopback: mux_word = loopback_q;
         page_build:    mux_word = build_number;
         page_pcbrev:   mux_word = {28'b0, pcbrev_i};
         page_uid_hi:   mux_word = sensors_i.unique_id[63:32];
         page_uid_lo:   mux_word = sensors_i.unique_id[31:0];
         page_temp:     mux_word = sensors_i.temperature;
         page_power:    mux_word = sensors_i.power;
         page_one:      mux_word = 32'd1;
         page_rs485:    mux_word = {31'b0, rs485_ro_i};
         default: begin
            // one status page per motor from the base upwards
            if (page >= page_motor_base && int'(motor_idx) < num_motors) begin
               mux_word = {28'b0, motor_stat_i[motor_idx]};
            end else begin
               mux_word = unused_page_word;
            end
         end
      endcase
   end

   // word is sampled on the receive clock enable only
   always_ff @(posedge gbt_rx_clkrs) begin
      if (rx_clken_i) begin
         readout_o <= mux_word;
      end
   end

endmodule

// ==== project.f ====
logic/mcoi_pkg.sv
logic/ps_buffer_reader.sv
logic/motor_io.sv
logic/readout_mux.sv
logic/mcoi_app_core.sv
test/mcoi_app_checker.sv
test/mcoi_app_tb.sv

// ==== test/mcoi_app_checker.sv ====
// result checker of the application core testbench
// compares the DUT outputs with expected values on the falling clock edge
module mcoi_app_checker import mcoi_pkg::*; #(
   parameter int num_motors = 16
) (
   input  logic                         gbt_rx_clkrs,
   // DUT outputs under watch
   input  logic [num_motors-1:0]        pl_boost_i,
   input  logic [num_motors-1:0]        pl_dir_i,
   input  logic [num_motors-1:0]        pl_en_i,
   input  logic [num_motors-1:0]        pl_clk_i,
   input  logic [num_motors*4-1:0]      status_frame_i,
   input  logic [31:0]                  readout_i,
   input  logic                         rs485_di_i,
   input  logic                         progress_i,
   // compare requests of one cycle each
   input  logic                         chk_pins_i,
   input  logic                         chk_stat_i,
   input  logic                         chk_readout_i,
   input  logic                         chk_di_i,
   // level, high while no sweep was requested
   input  logic                         chk_idle_i,
   input  motor_ctrl_t [num_motors-1:0] exp_ctrl_i,
   input  motor_stat_t [num_motors-1:0] exp_stat_i,
   input  logic [31:0]                  exp_readout_i,
   input  logic                         exp_di_i,
   // end of one test
   input  logic                         test_done_i,
   input  int                           test_idx_i,
   output int                           error_count_o,
   output int                           test_count_o
);

   // expected pin groups taken apart from the control structs
   logic [num_motors-1:0] exp_boost;
   logic [num_motors-1:0] exp_dir;
   logic [num_motors-1:0] exp_en;
   logic [num_motors-1:0] exp_clk;

   // mismatches inside the running test
   int test_errors;

   for (genvar m = 0; m < num_motors; m++) begin : g_exp
      assign exp_boost[m] = exp_ctrl_i[m].boost;
      assign exp_dir[m]   = exp_ctrl_i[m].dir;
      // enable pin carries the deactivate bit
      assign exp_en[m]    = exp_ctrl_i[m].deactivate;
      assign exp_clk[m]   = exp_ctrl_i[m].step_out;
   end

   initial begin
      error_count_o = 0;
      test_count_o  = 0;
      test_errors   = 0;
   end

   task automatic compare(input string name, input logic [63:0] exp,
                          input logic [63:0] act);
      if (act !== exp) begin
         $display("ERROR %s expected 0x%0h actual 0x%0h", name, exp, act);
         test_errors++;
         error_count_o++;
      end
   endtask

   // -------------------------------------------------------------------
   // outputs change on the rising edge and are compared on the falling one
   // -------------------------------------------------------------------
   always @(negedge gbt_rx_clkrs) begin
      if (chk_pins_i) begin
         compare("pl_boost_o", 64'(exp_boost), 64'(pl_boost_i));
         compare("pl_dir_o", 64'(exp_dir), 64'(pl_dir_i));
         compare("pl_en_o", 64'(exp_en), 64'(pl_en_i));
         compare("pl_clk_o", 64'(exp_clk), 64'(pl_clk_i));
      end
      if (chk_stat_i) begin
         compare("status_frame_o", 64'(exp_stat_i), 64'(status_frame_i));
      end
      if (chk_readout_i) begin
         compare("readout_o", 64'(exp_readout_i), 64'(readout_i));
      end
      if (chk_di_i) begin
         compare("rs485_di_o", 64'(exp_di_i), 64'(rs485_di_i));
      end
      // sweeps without the start flag keep progress low
      if (chk_idle_i) begin
         compare("progress_o", 64'h0, 64'(progress_i));
      end
      // one line per finished test
      if (test_done_i) begin
         if (test_errors == 0) begin
            $display("test %0d passed", test_idx_i);
         end else begin
            $display("test %0d failed with %0d mismatches", test_idx_i, test_errors);
         end
         test_count_o++;
         test_errors = 0;
      end
   end

endmodule

// ==== test/mcoi_app_tb.sv ====
// testbench of the gbt side application core
// table driven stimulus against a buffer model with results judged by the checker
module mcoi_app_tb import mcoi_pkg::*; ();

   localparam int          num_motors   = 16;
   localparam int          ps_addr_bits = 4;
   localparam logic [31:0] build_number = 32'h2022_0220;
   localparam int          clk_period   = 20;
   localparam int          num_tests    = 17;

   // what one table row exercises
   typedef enum logic [2:0] {
      t_pins,
      t_status,
      t_sweep,
      t_page,
      t_hold,
      t_loopback,
      t_rs485_di
   } test_kind_e;

   // stimulus of one row and the expected word of fixed pages
   typedef struct packed {
      test_kind_e  kind;
      logic [31:0] feedback;
      logic [31:0] page;
      logic        clken;
      logic        start;
      logic [15:0] pfail;
      logic [15:0] sw_a;
      logic [15:0] sw_b;
      logic [31:0] exp_word;
   } test_entry_t;

   // -------------------------------------------------------------------
   // dut ports named as on the core
   // -------------------------------------------------------------------
   logic                         gbt_rx_clkrs;
   logic                         reset_i;
   logic [15:0]                  ps_status_i;
   ps_word_t                     ps_dout_i;
   logic [ps_addr_bits-1:0]      ps_addr_o;
   logic                         progress_o;
   motor_ctrl_t [num_motors-1:0] motor_frame_i;
   logic [31:0]                  feedback_i;
   logic [num_motors-1:0]        pl_boost_o;
   logic [num_motors-1:0]        pl_dir_o;
   logic [num_motors-1:0]        pl_en_o;
   logic [num_motors-1:0]        pl_clk_o;
   logic [num_motors-1:0]        pl_pfail_i;
   logic [num_motors-1:0]        pl_sw_outa_i;
   logic [num_motors-1:0]        pl_sw_outb_i;
   logic [num_motors*4-1:0]      status_frame_o;
   logic                         rx_clken_i;
   logic [31:0]                  page_sel_i;
   logic                         page_valid_i;
   logic [3:0]                   pcbrev_i;
   logic                         rs485_ro_i;
   logic                         rs485_di_o;
   logic [31:0]                  readout_o;

   // compare requests and expected values for the checker
   logic                         chk_pins;
   logic                         chk_stat;
   logic                         chk_readout;
   logic                         chk_di;
   // high while no sweep was requested
   logic                         chk_idle;
   motor_ctrl_t [num_motors-1:0] exp_ctrl;
   motor_stat_t [num_motors-1:0] exp_stat;
   logic [31:0]                  exp_readout;
   logic                         exp_di;
   logic                         test_done;
   int                           test_idx;
   int                           error_count;
   int                           test_count;

   test_entry_t tests [num_tests];
   ps_word_t    ps_mem [16];
   integer      seed;
   // last readout word that a check expected
   logic [31:0] last_word;

   mcoi_app_core #(
      .num_motors   (num_motors),
      .ps_addr_bits (ps_addr_bits),
      .build_number (build_number)
   ) i_dut (.*);

   mcoi_app_checker #(
      .num_motors (num_motors)
   ) i_checker (
      .gbt_rx_clkrs   (gbt_rx_clkrs),
      .pl_boost_i     (pl_boost_o),
      .pl_dir_i       (pl_dir_o),
      .pl_en_i        (pl_en_o),
      .pl_clk_i       (pl_clk_o),
      .status_frame_i (status_frame_o),
      .readout_i      (readout_o),
      .rs485_di_i     (rs485_di_o),
      .progress_i     (progress_o),
      .chk_pins_i     (chk_pins),
      .chk_stat_i     (chk_stat),
      .chk_readout_i  (chk_readout),
      .chk_di_i       (chk_di),
      .chk_idle_i     (chk_idle),
      .exp_ctrl_i     (exp_ctrl),
      .exp_stat_i     (exp_stat),
      .exp_readout_i  (exp_readout),
      .exp_di_i       (exp_di),
      .test_done_i    (test_done),
      .test_idx_i     (test_idx),
      .error_count_o  (error_count),
      .test_count_o   (test_count)
   );

   initial begin
      gbt_rx_clkrs = 1'b0;
      forever #(clk_period / 2) gbt_rx_clkrs = ~gbt_rx_clkrs;
   end

   // -------------------------------------------------------------------
   // processor buffer model
   // -------------------------------------------------------------------
   // answers in the same cycle as the address
   assign ps_dout_i = ps_mem[ps_addr_o];

   initial begin
      // filler tags lie above the decoded ids
      for (int a = 0; a < 16; a++) begin
         ps_mem[a] = {8'h80 | 8'(a), 8'h00, 8'(a), ~8'(a)};
      end
      ps_mem[2]  = {8'd1, 8'h00, 16'h3A5C};
      ps_mem[3]  = {8'd2, 8'h00, 16'h9E01};
      ps_mem[5]  = {8'd4, 8'h00, 16'h47B2};
      // a tag nobody decodes
      ps_mem[6]  = {8'd7, 8'h00, 16'hFFFF};
      ps_mem[9]  = {8'd5, 8'h00, 16'hD00F};
      ps_mem[11] = {8'd10, 8'h00, 16'h0BB8};
      ps_mem[14] = {8'd13, 8'h00, 16'h0123};
   end

   // sensor values the buffer contents should give where later words win
   function automatic sensor_block_t decode_buffer();
      sensor_block_t s;
      s = '0;
      for (int a = 0; a < 16; a++) begin
         case (ps_mem[a].id)
            8'd1:    s.unique_id[15:0]   = ps_mem[a].value;
            8'd2:    s.unique_id[31:16]  = ps_mem[a].value;
            8'd4:    s.unique_id[47:32]  = ps_mem[a].value;
            8'd5:    s.unique_id[63:48]  = ps_mem[a].value;
            8'd10:   s.power[15:0]       = ps_mem[a].value;
            8'd13:   s.temperature[15:0] = ps_mem[a].value;
            default: ;
         endcase
      end
      return s;
   endfunction

   // -------------------------------------------------------------------
   // stimulus helpers start and end just after a rising edge
   // -------------------------------------------------------------------
   // compare strobes stay up for one cycle
   task automatic request_check(input logic pins, input logic stat,
                                input logic rdout, input logic di);
      chk_pins    <= pins;
      chk_stat    <= stat;
      chk_readout <= rdout;
      chk_di      <= di;
      @(posedge gbt_rx_clkrs);
      chk_pins    <= 1'b0;
      chk_stat    <= 1'b0;
      chk_readout <= 1'b0;
      chk_di      <= 1'b0;
   endtask

   task automatic check_page(input logic [31:0] sel, input logic [31:0] word);
      page_sel_i <= sel;
      rx_clken_i <= 1'b1;
      @(posedge gbt_rx_clkrs);
      exp_readout <= word;
      last_word = word;
      request_check(1'b0, 1'b0, 1'b1, 1'b0);
   endtask

   // progress is looked at on the falling edge
   task automatic wait_progress(input logic level);
      do begin
         @(negedge gbt_rx_clkrs);
      end while (progress_o !== level);
   endtask

   task automatic finish_test();
      test_done <= 1'b1;
      @(posedge gbt_rx_clkrs);
      test_done <= 1'b0;
   endtask

   // whole run bounded by a budget per test
   initial begin
      #(num_tests * 40 * clk_period);
      $display("timeout, the tests did not complete in the expected time");
      $display("ERRORS FOUND");
      $finish;
   end

   // -------------------------------------------------------------------
   // test table and main sequence
   // -------------------------------------------------------------------
   initial begin
      test_entry_t                  t;
      motor_ctrl_t [num_motors-1:0] frame;
      motor_stat_t [num_motors-1:0] stat;
      sensor_block_t                sens;
      int                           m;
      seed          = 48321;
      reset_i       = 1'b1;
      ps_status_i   = '0;
      motor_frame_i = '0;
      feedback_i    = '0;
      pl_pfail_i    = '1;
      pl_sw_outa_i  = '1;
      pl_sw_outb_i  = '1;
      rx_clken_i    = 1'b0;
      page_sel_i    = '0;
      page_valid_i  = 1'b0;
      pcbrev_i      = 4'h9;
      rs485_ro_i    = 1'b1;
      chk_pins      = 1'b0;
      chk_stat      = 1'b0;
      chk_readout   = 1'b0;
      chk_di        = 1'b0;
      chk_idle      = 1'b0;
      exp_ctrl      = '0;
      exp_stat      = '0;
      exp_readout   = '0;
      exp_di        = 1'b0;
      test_done     = 1'b0;
      test_idx      = 0;
      last_word     = '0;

      // kind, feedback, page, clken, start, pfail, sw a, sw b, expected word
      tests[0]  = '{t_pins, 32'h0, 32'h0, 1'b0, 1'b0, 16'hFFFF, 16'hFFFF, 16'hFFFF, 32'h0};
      tests[1]  = '{t_pins, interlock_word, 32'h0, 1'b0, 1'b0, '1, '1, '1, 32'h0};
      tests[2]  = '{t_pins, interlock_word, 32'h0, 1'b0, 1'b0, '1, '1, '1, 32'h0};
      tests[3]  = '{t_pins, interlock_word ^ 32'h1, 32'h0, 1'b0, 1'b0, '1, '1, '1, 32'h0};
      tests[4]  = '{t_status, 32'h0, 32'h13, 1'b1, 1'b0, 16'hA5C3, 16'h0F0F, 16'h3C96, 32'h0};
      tests[5]  = '{t_status, 32'h0, 32'h1F, 1'b1, 1'b0, 16'h7E81, 16'hF00D, 16'h1234, 32'h0};
      tests[6]  = '{t_sweep, 32'h0, 32'h0, 1'b0, 1'b1, '1, '1, '1, 32'h0};
      tests[7]  = '{t_page, 32'h0, 32'h1, 1'b1, 1'b0, '1, '1, '1, build_number};
      tests[8]  = '{t_page, 32'h0, 32'h2, 1'b1, 1'b0, '1, '1, '1, 32'h0000_0009};
      tests[9]  = '{t_page, 32'h0, 32'h7, 1'b1, 1'b0, '1, '1, '1, 32'h0000_0001};
      tests[10] = '{t_page, 32'h0, 32'h8, 1'b1, 1'b0, '1, '1, '1, 32'h0000_0001};
      tests[11] = '{t_page, 32'h0, 32'h9, 1'b1, 1'b0, '1, '1, '1, unused_page_word};
      // first motor page past the last motor
      tests[12] = '{t_page, 32'h0, 32'h20, 1'b1, 1'b0, '1, '1, '1, unused_page_word};
      tests[13] = '{t_hold, 32'h0, 32'h2, 1'b0, 1'b0, '1, '1, '1, 32'h0};
      tests[14] = '{t_loopback, 32'h0, 32'h8000_0000, 1'b1, 1'b0, '1, '1, '1, 32'h8000_0001};
      tests[15] = '{t_rs485_di, 32'h0, 32'h107, 1'b0, 1'b0, '1, '1, '1, 32'h1};
      tests[16] = '{t_rs485_di, 32'h0, 32'h007, 1'b0, 1'b0, '1, '1, '1, 32'h0};

      repeat (8) @(posedge gbt_rx_clkrs);
      reset_i  <= 1'b0;
      chk_idle <= 1'b1;

      for (int i = 0; i < num_tests; i++) begin
         t = tests[i];
         frame = {$random(seed), $random(seed)};
         test_idx      <= i;
         motor_frame_i <= frame;
         feedback_i    <= t.feedback;
         page_sel_i    <= t.page;
         rx_clken_i    <= t.clken;
         page_valid_i  <= (t.kind == t_loopback);
         ps_status_i   <= 16'(t.start) << ps_start_bit;
         pl_pfail_i    <= t.pfail;
         pl_sw_outa_i  <= t.sw_a;
         pl_sw_outb_i  <= t.sw_b;
         case (t.kind)
            t_pins: begin
               @(posedge gbt_rx_clkrs);
               // open loop parks every driver with all control bits high
               exp_ctrl <= (t.feedback == interlock_word) ? frame : '1;
               request_check(1'b1, 1'b0, 1'b0, 1'b0);
            end
            t_status: begin
               m = int'(t.page[7:0]) - 16;
               // pins are active low and there is no overheat line
               for (int k = 0; k < num_motors; k++) begin
                  stat[k].pfail    = ~t.pfail[k];
                  stat[k].raw_sw   = {~t.sw_b[k], ~t.sw_a[k]};
                  stat[k].overheat = 1'b0;
               end
               repeat (3) @(posedge gbt_rx_clkrs);
               exp_stat <= stat;
               request_check(1'b0, 1'b1, 1'b0, 1'b0);
               exp_readout <= {28'b0, stat[m]};
               last_word = {28'b0, stat[m]};
               request_check(1'b0, 1'b0, 1'b1, 1'b0);
            end
            t_sweep: begin
               chk_idle <= 1'b0;
               sens = decode_buffer();
               wait_progress(1'b1);
               @(posedge gbt_rx_clkrs);
               // sweep taken so the start flag drops
               ps_status_i <= '0;
               wait_progress(1'b0);
               // later sweeps run without the start flag
               chk_idle <= 1'b1;
               repeat (3) @(posedge gbt_rx_clkrs);
               check_page(32'(page_uid_hi), sens.unique_id[63:32]);
               check_page(32'(page_uid_lo), sens.unique_id[31:0]);
               check_page(32'(page_temp), sens.temperature);
               check_page(32'(page_power), sens.power);
            end
            t_page: begin
               @(posedge gbt_rx_clkrs);
               exp_readout <= t.exp_word;
               last_word = t.exp_word;
               request_check(1'b0, 1'b0, 1'b1, 1'b0);
            end
            t_hold: begin
               @(posedge gbt_rx_clkrs);
               exp_readout <= last_word;
               request_check(1'b0, 1'b0, 1'b1, 1'b0);
            end
            t_loopback: begin
               @(posedge gbt_rx_clkrs);
               page_valid_i <= 1'b0;
               // loopback register updates first and the readout word follows
               @(posedge gbt_rx_clkrs);
               exp_readout <= t.exp_word;
               last_word = t.exp_word;
               request_check(1'b0, 1'b0, 1'b1, 1'b0);
            end
            default: begin
               @(posedge gbt_rx_clkrs);
               exp_di <= t.exp_word[0];
               request_check(1'b0, 1'b0, 1'b0, 1'b1);
            end
         endcase
         finish_test();
      end

      @(posedge gbt_rx_clkrs);
      $display("%0d tests run, %0d errors", test_count, error_count);
      if (test_count != num_tests) begin
         $display("only %0d of %0d tests were reported", test_count, num_tests);
      end
      if (error_count == 0 && test_count == num_tests) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule
